// File: rtl/quant_post_pkg.sv
package quant_post_pkg;

  ////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////

  // partial sum from the array, 16 bits plus 8 headroom
  typedef logic signed [23:0] acc_t;
  // unsigned quantization scale E
  typedef logic        [15:0] scale_t;
  // acc times E
  typedef logic signed [39:0] prod_t;
  // low 32 bits of the product plus bias
  typedef logic signed [31:0] sum_t;
  typedef logic signed [7:0]  bias_t;
  // requant shift, 0 to 31
  typedef logic        [4:0]  shift_t;
  typedef logic signed [7:0]  q8_t;

  // one weight channel or two
  typedef enum logic {
    mode_8x8 = 1'b0,
    mode_1x8 = 1'b1
  } quant_mode_e;

  typedef struct packed {
    quant_mode_e mode;
    shift_t      shift;
    scale_t      scale;
    bias_t       bias0;
    bias_t       bias1;
  } qcfg_t;

  ////////////////////////////////////////
  // axi4-lite config port
  ////////////////////////////////////////

  typedef logic [7:0]  addr_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0]  resp_t;

  localparam addr_t addr_ctrl  = 8'h00;
  localparam addr_t addr_scale = 8'h04;
  localparam addr_t addr_bias  = 8'h08;
  // read only
  localparam addr_t addr_count = 8'h0c;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // master side channels
  typedef struct packed {
    addr_t      awaddr;
    logic       awvalid;
    data_t      wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       bready;
    addr_t      araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // slave side channels
  typedef struct packed {
    logic  awready;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
  } axil_rsp_t;

endpackage

// File: rtl/quant_cfg_regs.sv
module quant_cfg_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  quant_post_pkg::axil_req_t axil_req,
  output quant_post_pkg::axil_rsp_t axil_rsp,
  input  logic                      out_valid,
  output quant_post_pkg::qcfg_t     cfg
);

  logic                  wr_fire;
  logic                  rd_fire;
  logic                  wr_hit;
  logic                  rd_hit;
  logic                  bvalid;
  logic                  rvalid;
  quant_post_pkg::resp_t bresp;
  quant_post_pkg::resp_t rresp;
  quant_post_pkg::data_t rdata;
  quant_post_pkg::data_t rd_word;
  quant_post_pkg::data_t vec_count;

  // aw and w taken together, only with no response pending
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_fire = axil_req.arvalid && !rvalid;

  // writable targets, count excluded
  always_comb begin
    case (axil_req.awaddr)
      quant_post_pkg::addr_ctrl,
      quant_post_pkg::addr_scale,
      quant_post_pkg::addr_bias: wr_hit = 1'b1;
      default:                   wr_hit = 1'b0;
    endcase
  end

  // read mux
  always_comb begin
    rd_hit = 1'b1;
    case (axil_req.araddr)
      quant_post_pkg::addr_ctrl:  rd_word = {19'd0, cfg.shift, 7'd0, cfg.mode};
      quant_post_pkg::addr_scale: rd_word = {16'd0, cfg.scale};
      quant_post_pkg::addr_bias:  rd_word = {16'd0, cfg.bias1, cfg.bias0};
      quant_post_pkg::addr_count: rd_word = vec_count;
      default: begin
        // unmapped reads as zero
        rd_word = '0;
        rd_hit  = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // config registers, per byte strobes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg.mode  <= quant_post_pkg::mode_8x8;
      cfg.shift <= '0;
      cfg.scale <= 16'd1;
      cfg.bias0 <= '0;
      cfg.bias1 <= '0;
    end else if (wr_fire) begin
      case (axil_req.awaddr)
        quant_post_pkg::addr_ctrl: begin
          if (axil_req.wstrb[0]) cfg.mode <= quant_post_pkg::quant_mode_e'(axil_req.wdata[0]);
          // shift lives in byte 1
          if (axil_req.wstrb[1]) cfg.shift <= axil_req.wdata[12:8];
        end
        quant_post_pkg::addr_scale: begin
          if (axil_req.wstrb[0]) cfg.scale[7:0] <= axil_req.wdata[7:0];
          if (axil_req.wstrb[1]) cfg.scale[15:8] <= axil_req.wdata[15:8];
        end
        quant_post_pkg::addr_bias: begin
          if (axil_req.wstrb[0]) cfg.bias0 <= axil_req.wdata[7:0];
          if (axil_req.wstrb[1]) cfg.bias1 <= axil_req.wdata[15:8];
        end
        // count and unmapped untouched
        default: ;
      endcase
    end
  end

  // write response, held until bready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (axil_req.bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_hit ? quant_post_pkg::resp_okay : quant_post_pkg::resp_slverr;
    end
  end

  // read data, held until rready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_hit ? quant_post_pkg::resp_okay : quant_post_pkg::resp_slverr;
    end
  end

  // one count per output vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vec_count <= '0;
    end else if (out_valid) begin
      vec_count <= vec_count + 32'd1;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bresp   = bresp;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = rd_fire;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
    axil_rsp.rvalid  = rvalid;
  end

endmodule

// File: rtl/scale_mult.sv
module scale_mult #(
  parameter int lanes = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  quant_post_pkg::qcfg_t                cfg,
  input  logic                                 in_valid,
  input  quant_post_pkg::acc_t  [lanes-1:0]    in_acc,
  output logic                                 prod_valid,
  output quant_post_pkg::prod_t [lanes-1:0]    prod
);

  // E zero extended, so the signed multiply treats it as positive
  quant_post_pkg::prod_t                  scale_ext;
  quant_post_pkg::prod_t [lanes-1:0]      acc_ext;
  quant_post_pkg::prod_t [lanes-1:0]      prod_next;

  assign scale_ext = {24'd0, cfg.scale};

  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      // sign extend each lane to product width
      acc_ext[i]   = {{16{in_acc[i][23]}}, in_acc[i]};
      // fits in 40 bits, |acc| < 2^23 and E < 2^16
      prod_next[i] = $signed(acc_ext[i]) * $signed(scale_ext);
    end
  end

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= in_valid;
    end
  end

  // payload only loads with a live vector
  always_ff @(posedge clk) begin
    if (in_valid) begin
      prod <= prod_next;
    end
  end

endmodule

// File: rtl/bias_add.sv
module bias_add #(
  parameter int lanes = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  quant_post_pkg::qcfg_t                cfg,
  input  logic                                 prod_valid,
  input  quant_post_pkg::prod_t [lanes-1:0]    prod,
  output logic                                 sum_valid,
  output quant_post_pkg::sum_t  [lanes-1:0]    sum
);

  // first lane of the second weight channel
  localparam int half_lanes = lanes / 2;

  quant_post_pkg::bias_t [lanes-1:0] lane_bias;
  quant_post_pkg::sum_t  [lanes-1:0] bias_ext;
  quant_post_pkg::sum_t  [lanes-1:0] sum_next;

  ////////////////////////////////////////
  // bias select and add
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      // 8x8: all lanes on bias0
      // 1x8: upper half on bias1
      if (cfg.mode == quant_post_pkg::mode_1x8 && i >= half_lanes) begin
        lane_bias[i] = cfg.bias1;
      end else begin
        lane_bias[i] = cfg.bias0;
      end
      bias_ext[i] = {{24{lane_bias[i][7]}}, lane_bias[i]};
      // low 32 bits of the product, add wraps
      sum_next[i] = prod[i][31:0] + bias_ext[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      sum <= sum_next;
    end
  end

endmodule

// File: rtl/requant_clip.sv
module requant_clip #(
  parameter int lanes = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  quant_post_pkg::qcfg_t                cfg,
  input  logic                                 sum_valid,
  input  quant_post_pkg::sum_t  [lanes-1:0]    sum,
  output logic                                 out_valid,
  output quant_post_pkg::q8_t   [lanes-1:0]    out_q
);

  // one extra bit so the rounding add cannot overflow
  logic signed [32:0]             half;
  logic signed [lanes-1:0][32:0]  widened;
  logic signed [lanes-1:0][32:0]  shifted;
  quant_post_pkg::q8_t [lanes-1:0] q_next;

  // half an lsb of the shifted result, none at shift 0
  always_comb begin
    if (cfg.shift == 5'd0) begin
      half = '0;
    end else begin
      half = 33'sd1 <<< (cfg.shift - 5'd1);
    end
  end

  ////////////////////////////////////////
  // round, shift, saturate
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      widened[i] = $signed({sum[i][31], sum[i]}) + half;
      // arithmetic shift, floor after the half add gives round half up
      shifted[i] = $signed(widened[i]) >>> cfg.shift;
      if ($signed(shifted[i]) > 33'sd127) begin
        q_next[i] = 8'sd127;
      end else if ($signed(shifted[i]) < -33'sd128) begin
        q_next[i] = -8'sd128;
      end else begin
        q_next[i] = shifted[i][7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      out_q <= q_next;
    end
  end

endmodule

// File: rtl/quant_post_top.sv
module quant_post_top #(
  parameter int lanes = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  quant_post_pkg::axil_req_t            axil_req,
  output quant_post_pkg::axil_rsp_t            axil_rsp,
  input  logic                                 in_valid,
  input  quant_post_pkg::acc_t  [lanes-1:0]    in_acc,
  output logic                                 out_valid,
  output quant_post_pkg::q8_t   [lanes-1:0]    out_q
);

  // one config image shared by all three stages
  quant_post_pkg::qcfg_t             cfg;
  logic                              prod_valid;
  quant_post_pkg::prod_t [lanes-1:0] prod;
  logic                              sum_valid;
  quant_post_pkg::sum_t  [lanes-1:0] sum;

  // registers, count fed from the last stage
  quant_cfg_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .out_valid (out_valid),
    .cfg       (cfg)
  );

  ////////////////////////////////////////
  // three stage pipe, in to out is 3 clk
  ////////////////////////////////////////

  scale_mult #(.lanes(lanes)) u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .in_valid   (in_valid),
    .in_acc     (in_acc),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  bias_add #(.lanes(lanes)) u_bias (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .prod_valid (prod_valid),
    .prod       (prod),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  requant_clip #(.lanes(lanes)) u_clip (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .sum_valid (sum_valid),
    .sum       (sum),
    .out_valid (out_valid),
    .out_q     (out_q)
  );

endmodule

// File: tb/quant_post_checker.sv
module quant_post_checker #(
  parameter int lanes = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  quant_post_pkg::axil_req_t         axil_req,
  input  quant_post_pkg::axil_rsp_t         axil_rsp,
  input  logic                              in_valid,
  input  quant_post_pkg::acc_t [lanes-1:0]  in_acc,
  input  logic                              out_valid,
  input  quant_post_pkg::q8_t  [lanes-1:0]  out_q,
  input  quant_post_pkg::data_t             exp_rdata,
  input  quant_post_pkg::resp_t             exp_resp,
  input  logic                              test_done,
  input  int                                test_id,
  output int                                pending,
  output int                                checks,
  output int                                errors,
  output int                                tests_failed
);

  typedef quant_post_pkg::q8_t [lanes-1:0] qvec_t;

  // own image of the config built from accepted writes
  quant_post_pkg::qcfg_t cfg;
  qvec_t                 exp_vec;
  qvec_t                 exp_q [$];
  longint                due_q [$];
  longint                cyc;
  int                    test_checks;
  int                    test_errors;

  // acc times E then bias, round half up, shift and clip
  function automatic quant_post_pkg::q8_t expect_lane(quant_post_pkg::acc_t acc,
                                                      quant_post_pkg::qcfg_t c, int lane);
    longint             p;
    longint             b;
    logic signed [31:0] s32;
    longint             s;
    p = longint'(acc) * longint'(c.scale);
    // upper half takes bias1 only in 1x8
    if (c.mode == quant_post_pkg::mode_1x8 && lane >= lanes / 2) begin
      b = longint'($signed(c.bias1));
    end else begin
      b = longint'($signed(c.bias0));
    end
    s32 = p[31:0] + b[31:0];
    s   = s32;
    if (c.shift != 5'd0) begin
      s = s + (longint'(1) << (int'(c.shift) - 1));
    end
    s = s >>> c.shift;
    if (s > 127) return 8'sd127;
    if (s < -128) return -8'sd128;
    return s[7:0];
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] got);
    checks++;
    test_checks++;
    if (expected !== got) begin
      $display("Error %s: expected 0x%0h, got 0x%0h", name, expected, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(string msg);
    $display("%s at cycle %0d", msg, cyc);
    errors++;
    test_errors++;
  endtask

  ////////////////////////////////////////
  // per cycle watch
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      cfg.mode  = quant_post_pkg::mode_8x8;
      cfg.shift = '0;
      cfg.scale = 16'd1;
      cfg.bias0 = '0;
      cfg.bias1 = '0;
      exp_q.delete();
      due_q.delete();
      cyc          = 0;
      pending      = 0;
      checks       = 0;
      errors       = 0;
      tests_failed = 0;
      test_checks  = 0;
      test_errors  = 0;
    end else begin
      // axi responses
      if (axil_rsp.bvalid && axil_req.bready) begin
        check_value("bresp", {30'd0, exp_resp}, {30'd0, axil_rsp.bresp});
      end
      if (axil_rsp.rvalid && axil_req.rready) begin
        check_value("rdata", exp_rdata, axil_rsp.rdata);
        check_value("rresp", {30'd0, exp_resp}, {30'd0, axil_rsp.rresp});
      end
      // aw and w are taken in the same cycle
      if (axil_rsp.awready !== axil_rsp.wready) begin
        report_failure("awready and wready were not raised together");
      end
      // output side before new inputs
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          report_failure("out_valid high with no vector in flight");
        end else begin
          if (due_q[0] != cyc) begin
            report_failure("output vector arrived off the 3 cycle latency");
          end
          for (int i = 0; i < lanes; i++) begin
            check_value($sformatf("out_q[%0d]", i), {24'd0, exp_q[0][i]}, {24'd0, out_q[i]});
          end
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end else if (due_q.size() > 0 && due_q[0] == cyc) begin
        report_failure("no output vector 3 cycles after its input");
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
      // accepted write with per byte strobes
      if (axil_req.awvalid && axil_req.wvalid && axil_rsp.awready) begin
        case (axil_req.awaddr)
          quant_post_pkg::addr_ctrl: begin
            if (axil_req.wstrb[0]) cfg.mode = quant_post_pkg::quant_mode_e'(axil_req.wdata[0]);
            if (axil_req.wstrb[1]) cfg.shift = axil_req.wdata[12:8];
          end
          quant_post_pkg::addr_scale: begin
            if (axil_req.wstrb[0]) cfg.scale[7:0] = axil_req.wdata[7:0];
            if (axil_req.wstrb[1]) cfg.scale[15:8] = axil_req.wdata[15:8];
          end
          quant_post_pkg::addr_bias: begin
            if (axil_req.wstrb[0]) cfg.bias0 = axil_req.wdata[7:0];
            if (axil_req.wstrb[1]) cfg.bias1 = axil_req.wdata[15:8];
          end
          default: ;
        endcase
      end
      // new vector due 3 edges on
      if (in_valid) begin
        for (int i = 0; i < lanes; i++) begin
          exp_vec[i] = expect_lane(in_acc[i], cfg, i);
        end
        exp_q.push_back(exp_vec);
        due_q.push_back(cyc + 3);
      end
      if (test_done) begin
        $display("test %0d done: %0d checks, %0d errors", test_id, test_checks, test_errors);
        if (test_errors > 0) tests_failed++;
        test_checks = 0;
        test_errors = 0;
      end
      cyc++;
      pending = exp_q.size();
    end
  end

endmodule

// File: tb/tb_quant_post.sv
module tb_quant_post;

  localparam int lanes = 8;

  localparam logic [1:0] k_write = 2'd0;
  localparam logic [1:0] k_read  = 2'd1;
  localparam logic [1:0] k_burst = 2'd2;

  // one table row: write, read or burst of vectors
  typedef struct packed {
    logic [1:0]            kind;
    logic [3:0]            test;
    logic                  last;
    quant_post_pkg::addr_t addr;
    quant_post_pkg::data_t data;
    logic [3:0]            strb;
    quant_post_pkg::resp_t resp;
    logic [7:0]            count;
  } step_t;

  logic                                clk;
  logic                                rst_n;
  quant_post_pkg::axil_req_t           axil_req;
  quant_post_pkg::axil_rsp_t           axil_rsp;
  logic                                in_valid;
  quant_post_pkg::acc_t  [lanes-1:0]   in_acc;
  logic                                out_valid;
  quant_post_pkg::q8_t   [lanes-1:0]   out_q;
  quant_post_pkg::data_t               exp_rdata;
  quant_post_pkg::resp_t               exp_resp;
  logic                                test_done;
  int                                  test_id;
  int                                  tests_run;
  int                                  pending;
  int                                  checks;
  int                                  errors;
  int                                  tests_failed;
  logic                                table_ready;
  logic [31:0]                         seed;
  step_t                               steps [$];
  quant_post_pkg::acc_t                edge_vals [16];

  always #20 clk = ~clk;

  quant_post_top #(.lanes(lanes)) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .in_valid  (in_valid),
    .in_acc    (in_acc),
    .out_valid (out_valid),
    .out_q     (out_q)
  );

  quant_post_checker #(.lanes(lanes)) u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .in_valid     (in_valid),
    .in_acc       (in_acc),
    .out_valid    (out_valid),
    .out_q        (out_q),
    .exp_rdata    (exp_rdata),
    .exp_resp     (exp_resp),
    .test_done    (test_done),
    .test_id      (test_id),
    .pending      (pending),
    .checks       (checks),
    .errors       (errors),
    .tests_failed (tests_failed)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_step(logic [1:0] kind, int test, logic last, quant_post_pkg::addr_t addr,
                          quant_post_pkg::data_t data, logic [3:0] strb,
                          quant_post_pkg::resp_t resp, int count);
    step_t s;
    s.kind  = kind;
    s.test  = test[3:0];
    s.last  = last;
    s.addr  = addr;
    s.data  = data;
    s.strb  = strb;
    s.resp  = resp;
    s.count = count[7:0];
    steps.push_back(s);
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    // clip, half lsb at shift 4, int8 edges, zero
    edge_vals = '{24'h7fffff, 24'h800000, 24'h000008, 24'hfffff8, 24'h000018, 24'hffffe8,
                  24'h000007, 24'hfffff9, 24'h00007f, 24'h000080, 24'hffff80, 24'hffff7f,
                  24'h000000, 24'h000001, 24'hffffff, 24'h0007f8};
    // reset values
    add_step(k_read, 1, 0, quant_post_pkg::addr_ctrl, 32'h0, 4'h0, quant_post_pkg::resp_okay, 0);
    add_step(k_read, 1, 0, quant_post_pkg::addr_scale, 32'h1, 4'h0, quant_post_pkg::resp_okay, 0);
    add_step(k_read, 1, 0, quant_post_pkg::addr_bias, 32'h0, 4'h0, quant_post_pkg::resp_okay, 0);
    add_step(k_read, 1, 1, quant_post_pkg::addr_count, 32'h0, 4'h0, quant_post_pkg::resp_okay, 0);
    // 8x8, E 9, shift 7, bias0 0x25
    add_step(k_write, 2, 0, quant_post_pkg::addr_scale, 32'h9, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_write, 2, 0, quant_post_pkg::addr_bias, 32'h25, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_write, 2, 0, quant_post_pkg::addr_ctrl, 32'h700, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_burst, 2, 1, 8'h0, 32'h0, 4'h0, quant_post_pkg::resp_okay, 24);
    // 1x8, bias1 negative
    add_step(k_write, 3, 0, quant_post_pkg::addr_scale, 32'h1, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_write, 3, 0, quant_post_pkg::addr_bias, 32'he310, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_write, 3, 0, quant_post_pkg::addr_ctrl, 32'h401, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_burst, 3, 1, 8'h0, 32'h0, 4'h0, quant_post_pkg::resp_okay, 20);
    // edge values at shift 4, then shift 0
    add_step(k_write, 4, 0, quant_post_pkg::addr_bias, 32'h0, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_write, 4, 0, quant_post_pkg::addr_ctrl, 32'h400, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_burst, 4, 0, 8'h0, 32'h1, 4'h0, quant_post_pkg::resp_okay, 4);
    add_step(k_write, 4, 0, quant_post_pkg::addr_ctrl, 32'h0, 4'hf, quant_post_pkg::resp_okay, 0);
    add_step(k_burst, 4, 1, 8'h0, 32'h1, 4'h0, quant_post_pkg::resp_okay, 4);
    // slverr targets, then partial strobes
    add_step(k_write, 5, 0, 8'h10, 32'hffffffff, 4'hf, quant_post_pkg::resp_slverr, 0);
    add_step(k_write, 5, 0, quant_post_pkg::addr_count, 32'h55, 4'hf,
             quant_post_pkg::resp_slverr, 0);
    add_step(k_read, 5, 0, 8'h10, 32'h0, 4'h0, quant_post_pkg::resp_slverr, 0);
    add_step(k_read, 5, 0, quant_post_pkg::addr_ctrl, 32'h0, 4'h0, quant_post_pkg::resp_okay, 0);
    add_step(k_read, 5, 0, quant_post_pkg::addr_scale, 32'h1, 4'h0, quant_post_pkg::resp_okay, 0);
    add_step(k_write, 5, 0, quant_post_pkg::addr_scale, 32'habcd, 4'h2,
             quant_post_pkg::resp_okay, 0);
    add_step(k_read, 5, 0, quant_post_pkg::addr_scale, 32'hab01, 4'h0,
             quant_post_pkg::resp_okay, 0);
    add_step(k_write, 5, 0, quant_post_pkg::addr_bias, 32'h7f80, 4'h1, quant_post_pkg::resp_okay, 0);
    add_step(k_read, 5, 1, quant_post_pkg::addr_bias, 32'h80, 4'h0, quant_post_pkg::resp_okay, 0);
    // 24 + 20 + 4 + 4 vectors sent
    add_step(k_read, 6, 1, quant_post_pkg::addr_count, 32'd52, 4'h0,
             quant_post_pkg::resp_okay, 0);
  endtask

  ////////////////////////////////////////
  // bus and stream drivers
  ////////////////////////////////////////

  task automatic axi_write(quant_post_pkg::addr_t a, quant_post_pkg::data_t d, logic [3:0] s,
                           quant_post_pkg::resp_t r);
    @(posedge clk);
    exp_resp         <= r;
    axil_req.awaddr  <= a;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= d;
    axil_req.wstrb   <= s;
    axil_req.wvalid  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    // bready held high, response taken on the next edge
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic axi_read(quant_post_pkg::addr_t a, quant_post_pkg::data_t d,
                          quant_post_pkg::resp_t r);
    @(posedge clk);
    exp_rdata        <= d;
    exp_resp         <= r;
    axil_req.araddr  <= a;
    axil_req.arvalid <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    @(posedge clk);
  endtask

  // back to back vectors, lcg lanes or the edge set
  task automatic send_burst(int n, logic use_edges);
    quant_post_pkg::acc_t [lanes-1:0] vec;
    for (int v = 0; v < n; v++) begin
      @(posedge clk);
      for (int i = 0; i < lanes; i++) begin
        if (use_edges) begin
          vec[i] = edge_vals[(v * lanes + i) % 16];
        end else begin
          seed   = lcg_next(seed);
          vec[i] = {{12{seed[27]}}, seed[27:16]};
        end
      end
      in_valid <= 1'b1;
      in_acc   <= vec;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    // drain, checker retires every vector
    @(negedge clk);
    while (pending != 0) @(negedge clk);
  endtask

  task automatic finish_test(int t);
    @(posedge clk);
    test_id   <= t;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
    tests_run++;
  endtask

  initial begin : main
    clk              = 1'b0;
    rst_n            = 1'b0;
    axil_req         = '0;
    axil_req.bready  = 1'b1;
    axil_req.rready  = 1'b1;
    in_valid         = 1'b0;
    in_acc           = '0;
    exp_rdata        = '0;
    exp_resp         = '0;
    test_done        = 1'b0;
    test_id          = 0;
    tests_run        = 0;
    seed             = 32'h92c4;
    table_ready      = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    foreach (steps[i]) begin
      case (steps[i].kind)
        k_write: axi_write(steps[i].addr, steps[i].data, steps[i].strb, steps[i].resp);
        k_read:  axi_read(steps[i].addr, steps[i].data, steps[i].resp);
        default: send_burst(steps[i].count, steps[i].data[0]);
      endcase
      if (steps[i].last) finish_test(steps[i].test);
    end
    @(posedge clk);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // limit from table length, 4x margin
  initial begin : watchdog
    int budget;
    budget = 0;
    wait (table_ready);
    foreach (steps[i]) begin
      budget += (steps[i].kind == k_burst) ? steps[i].count + 8 : 8;
    end
    budget = budget * 4 + 200;
    repeat (budget) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", budget);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: build.f
rtl/quant_post_pkg.sv
rtl/quant_cfg_regs.sv
rtl/scale_mult.sv
rtl/bias_add.sv
rtl/requant_clip.sv
rtl/quant_post_top.sv
tb/quant_post_checker.sv
tb/tb_quant_post.sv

// File: Bender.yml
package:
  name: quant_post

sources:
  - rtl/quant_post_pkg.sv
  - rtl/quant_cfg_regs.sv
  - rtl/scale_mult.sv
  - rtl/bias_add.sv
  - rtl/requant_clip.sv
  - rtl/quant_post_top.sv
  - target: test
    files:
      - tb/quant_post_checker.sv
      - tb/tb_quant_post.sv
